/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = router_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log
PASS  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* flist.f */
logic/noc_params_pkg.sv
logic/noc_types_pkg.sv
logic/input_buffer.sv
logic/route_compute.sv
logic/switch_allocator.sv
logic/crossbar.sv
logic/router_top.sv
testbench/tb_clock_gen.sv
testbench/router_tb.sv

/* logic/crossbar.sv */
// Registered 5x5 crossbar
// Moves each granted head flit to its output port register
`timescale 1ns/1ns
`default_nettype none

module crossbar (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic [noc_params_pkg::flit_width-1:0]  head_data [noc_types_pkg::num_ports],
    input  wire logic [noc_types_pkg::num_ports-1:0]    grant [noc_types_pkg::num_ports],
    output logic      [noc_params_pkg::flit_width-1:0]  out_data [noc_types_pkg::num_ports],
    output logic                                        out_valid [noc_types_pkg::num_ports]
);

    localparam int np = noc_types_pkg::num_ports;

    logic [noc_params_pkg::flit_width-1:0] sel_data [np];

    // AND-OR mux, grant is one-hot or zero
    always_comb begin
        for (int o = 0; o < np; o++) begin
            sel_data[o] = '0;
            for (int i = 0; i < np; i++) begin
                if (grant[o][i]) begin
                    sel_data[o] = sel_data[o] | head_data[i];
                end
            end
        end
    end

    // Output flit register, only loads when something wins
    always_ff @(posedge clk) begin
        for (int o = 0; o < np; o++) begin
            if (|grant[o]) begin
                out_data[o] <= sel_data[o];
            end
        end
    end

    // One-cycle valid pulse per flit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < np; o++) begin
                out_valid[o] <= 1'b0;
            end
        end else begin
            for (int o = 0; o < np; o++) begin
                out_valid[o] <= |grant[o];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/input_buffer.sv */
// Input port flit FIFO
// Circular buffer with head flit exposed for route compute and crossbar
`timescale 1ns/1ns
`default_nettype none

module input_buffer (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 push,
    input  wire logic [noc_params_pkg::flit_width-1:0] push_data,
    input  wire logic                                 pop,
    output logic      [noc_params_pkg::flit_width-1:0] head_data,
    output logic                                      head_valid,
    output logic                                      full
);

    // Flit storage
    logic [noc_params_pkg::flit_width-1:0] mem [noc_params_pkg::buffer_depth];

    logic [noc_params_pkg::ptr_bits-1:0] wr_ptr;
    logic [noc_params_pkg::ptr_bits-1:0] rd_ptr;
    // One extra bit so a full buffer is representable
    logic [noc_params_pkg::ptr_bits:0]   count;

    logic push_ok;
    logic pop_ok;

    assign full       = (count == (noc_params_pkg::ptr_bits + 1)'(noc_params_pkg::buffer_depth));
    assign head_valid = (count != '0);
    // Head is read straight out of the array, so a fresh write is head right away
    assign head_data  = mem[rd_ptr];

    // Ignore requests that would overflow or underflow
    assign push_ok = push && !full;
    assign pop_ok  = pop && head_valid;

    // Storage write
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                // Wrap at the last entry
                wr_ptr <= (wr_ptr == noc_params_pkg::ptr_bits'(noc_params_pkg::buffer_depth - 1))
                          ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == noc_params_pkg::ptr_bits'(noc_params_pkg::buffer_depth - 1))
                          ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Upstream must honour credits or local ready
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));

    // Allocator only grants heads that exist
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && !head_valid));

endmodule

`default_nettype wire

/* logic/noc_params_pkg.sv */
// NoC parameter package
// Mesh geometry, flit field layout and input buffer sizing
`default_nettype none

package noc_params_pkg;

    // Flit is destination router id on top, payload below
    localparam int flit_width     = 16;
    localparam int router_id_bits = 4;

    // 4 by 4 mesh, router id = row * mesh_cols + col
    localparam int mesh_cols = 4;
    localparam int mesh_rows = 4;

    // Input FIFO depth in flits
    // Downstream credits start at this value too
    localparam int buffer_depth = 4;

    // Credit counter must reach buffer_depth
    localparam int credit_bits = 3;

    // Read and write pointer width of the FIFO
    localparam int ptr_bits = 2;

endpackage

`default_nettype wire

/* logic/noc_types_pkg.sv */
// NoC type package
// Port directions and port count shared by all per-port arrays
`default_nettype none

package noc_types_pkg;

    // Local plus four mesh neighbours
    localparam int num_ports = 5;

    // Enum value is the bit position in every one-hot port vector
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_north = 3'd1,
        port_south = 3'd2,
        port_east  = 3'd3,
        port_west  = 3'd4
    } port_dir_e;

    // Credit and upstream pulse vectors skip the local port
    // Bit index there is port value minus one

endpackage

`default_nettype wire

/* logic/route_compute.sv */
// Dimension order route compute
// XY routing of the head flit destination into a one-hot output request
`timescale 1ns/1ns
`default_nettype none

module route_compute #(
    parameter logic [noc_params_pkg::router_id_bits-1:0] router_id = '0
) (
    input  wire logic                                      head_valid,
    input  wire logic [noc_params_pkg::router_id_bits-1:0] dest_router,
    output logic      [noc_types_pkg::num_ports-1:0]       req
);

    // Coordinate widths
    localparam int col_bits = $clog2(noc_params_pkg::mesh_cols);
    localparam int row_bits = $clog2(noc_params_pkg::mesh_rows);

    // Own position in the mesh
    localparam logic [col_bits-1:0] own_col = col_bits'(router_id % noc_params_pkg::mesh_cols);
    localparam logic [row_bits-1:0] own_row = row_bits'(router_id / noc_params_pkg::mesh_cols);

    logic [col_bits-1:0] dest_col;
    logic [row_bits-1:0] dest_row;

    // Column is id modulo row length, row is id divided by it
    assign dest_col = col_bits'(dest_router % noc_params_pkg::mesh_cols);
    assign dest_row = row_bits'(dest_router / noc_params_pkg::mesh_cols);

    always_comb begin
        req = '0;
        if (head_valid) begin
            // X first
            if (dest_col > own_col) begin
                req[noc_types_pkg::port_east] = 1'b1;
            end else if (dest_col < own_col) begin
                req[noc_types_pkg::port_west] = 1'b1;
            // Then Y, row numbers grow southwards
            end else if (dest_row > own_row) begin
                req[noc_types_pkg::port_south] = 1'b1;
            end else if (dest_row < own_row) begin
                req[noc_types_pkg::port_north] = 1'b1;
            end else begin
                // Arrived, eject to local
                req[noc_types_pkg::port_local] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/router_top.sv */
// Mesh router top level
// Five input FIFOs, XY route compute, switch allocator and registered crossbar
`timescale 1ns/1ns
`default_nettype none

module router_top #(
    parameter logic [noc_params_pkg::router_id_bits-1:0] router_id = '0
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  in_valid [noc_types_pkg::num_ports],
    input  wire logic [noc_params_pkg::flit_width-1:0] in_data [noc_types_pkg::num_ports],
    output logic                                       local_in_ready,
    input  wire logic [noc_types_pkg::num_ports-2:0]   dwnstr_credit_increment,
    output logic      [noc_types_pkg::num_ports-2:0]   upstr_credit_increment,
    output logic      [noc_params_pkg::flit_width-1:0] out_data [noc_types_pkg::num_ports],
    output logic                                       out_valid [noc_types_pkg::num_ports]
);

    localparam int np = noc_types_pkg::num_ports;

    // Buffer heads
    logic [noc_params_pkg::flit_width-1:0] head_data [np];
    logic                                  head_valid [np];
    logic                                  buf_full [np];

    // Allocator handshake
    logic [np-1:0] req [np];
    logic [np-1:0] grant [np];
    logic          pop [np];

    // Mesh ports are credit controlled, local NIC watches ready
    assign local_in_ready = !buf_full[noc_types_pkg::port_local];

    for (genvar p = 0; p < np; p++) begin : g_port
        input_buffer u_buf (
            .clk        (clk),
            .rst_n      (rst_n),
            .push       (in_valid[p]),
            .push_data  (in_data[p]),
            .pop        (pop[p]),
            .head_data  (head_data[p]),
            .head_valid (head_valid[p]),
            .full       (buf_full[p])
        );

        // Destination sits in the top bits of the head flit
        route_compute #(
            .router_id (router_id)
        ) u_rc (
            .head_valid  (head_valid[p]),
            .dest_router (head_data[p][noc_params_pkg::flit_width-1 -:
                                       noc_params_pkg::router_id_bits]),
            .req         (req[p])
        );
    end

    switch_allocator u_sa (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .req                     (req),
        .dwnstr_credit_increment (dwnstr_credit_increment),
        .grant                   (grant),
        .pop                     (pop),
        .upstr_credit_increment  (upstr_credit_increment)
    );

    crossbar u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_data (head_data),
        .grant     (grant),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

/* logic/switch_allocator.sv */
// Switch allocator
// Per-output round-robin arbitration gated by downstream credits
// Drives crossbar grants, buffer pops and upstream credit returns
`timescale 1ns/1ns
`default_nettype none

module switch_allocator (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [noc_types_pkg::num_ports-1:0]   req [noc_types_pkg::num_ports],
    input  wire logic [noc_types_pkg::num_ports-2:0]   dwnstr_credit_increment,
    output logic      [noc_types_pkg::num_ports-1:0]   grant [noc_types_pkg::num_ports],
    output logic                                       pop [noc_types_pkg::num_ports],
    output logic      [noc_types_pkg::num_ports-2:0]   upstr_credit_increment
);

    localparam int np = noc_types_pkg::num_ports;

    // Highest priority input per output
    noc_types_pkg::port_dir_e rr_ptr [np];
    noc_types_pkg::port_dir_e rr_nxt [np];

    // Credits for north, south, east, west outputs
    logic [noc_params_pkg::credit_bits-1:0] credit [np-1];

    // Requests regrouped by output, grants regrouped by input
    logic [np-1:0] req_col [np];
    logic [np-1:0] in_grant [np];
    logic          can_send [np];

    // Pick first requester at or after start, wrapping around
    function automatic logic [np-1:0] rr_pick(input logic [np-1:0] reqs,
                                              input noc_types_pkg::port_dir_e start);
        logic [np-1:0] pick;
        logic          found;
        int            idx;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < np; i++) begin
            idx = int'(start) + i;
            if (idx >= np) begin
                idx = idx - np;
            end
            if (!found && reqs[idx]) begin
                pick[idx] = 1'b1;
                found     = 1'b1;
            end
        end
        return pick;
    endfunction

    // Local ejection never runs out of credit
    assign can_send[0] = 1'b1;
    for (genvar c = 0; c < np - 1; c++) begin : g_can_send
        assign can_send[c+1] = (credit[c] != '0);
    end

    // Transpose input requests and arbitrate each output
    always_comb begin
        for (int o = 0; o < np; o++) begin
            for (int i = 0; i < np; i++) begin
                req_col[o][i] = req[i][o];
            end
            grant[o] = can_send[o] ? rr_pick(req_col[o], rr_ptr[o]) : '0;
        end
    end

    // Inputs request one output each, so at most one grant per input
    always_comb begin
        for (int i = 0; i < np; i++) begin
            for (int o = 0; o < np; o++) begin
                in_grant[i][o] = grant[o][i];
            end
            pop[i] = |in_grant[i];
        end
    end

    // Freed slot returns a credit to the upstream router
    always_comb begin
        for (int c = 0; c < np - 1; c++) begin
            upstr_credit_increment[c] = pop[c+1];
        end
    end

    // Next priority is the input after the winner
    always_comb begin
        for (int o = 0; o < np; o++) begin
            rr_nxt[o] = rr_ptr[o];
            for (int i = 0; i < np; i++) begin
                if (grant[o][i]) begin
                    rr_nxt[o] = (i == np - 1) ? noc_types_pkg::port_local
                                              : noc_types_pkg::port_dir_e'(i + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < np; o++) begin
                rr_ptr[o] <= noc_types_pkg::port_local;
            end
        end else begin
            rr_ptr <= rr_nxt;
        end
    end

    // Spend on grant, refill on downstream pulse, both at once is no change
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < np - 1; c++) begin
                credit[c] <= noc_params_pkg::credit_bits'(noc_params_pkg::buffer_depth);
            end
        end else begin
            for (int c = 0; c < np - 1; c++) begin
                case ({|grant[c+1], dwnstr_credit_increment[c]})
                    2'b10:   credit[c] <= credit[c] - 1'b1;
                    2'b01:   credit[c] <= credit[c] + 1'b1;
                    default: credit[c] <= credit[c];
                endcase
            end
        end
    end

    for (genvar i = 0; i < np; i++) begin : g_grant_chk
        // An input wins at most one output, route compute asks for one only
        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(in_grant[i]));
    end

    for (genvar c = 0; c < np - 1; c++) begin : g_credit_chk
        // Downstream never returns more than its buffer holds
        a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
            credit[c] <= noc_params_pkg::credit_bits'(noc_params_pkg::buffer_depth));
    end

endmodule

`default_nettype wire

/* testbench/router_tb.sv */
// Mesh router testbench
// Directed tests for reset, XY routing, credit return, arbitration and back-pressure
`timescale 1ns/1ns
`default_nettype none

module router_tb;

    localparam int np              = noc_types_pkg::num_ports;
    localparam int clk_period      = 100;
    localparam int stim_delay      = 1;
    localparam int num_tests       = 5;
    localparam int payload_bits    = noc_params_pkg::flit_width - noc_params_pkg::router_id_bits;
    localparam int east_credit_bit = int'(noc_types_pkg::port_east) - 1;
    localparam logic [31:0] lfsr_seed = 32'h993b_6448;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    // Router under test sits at column 1, row 1
    localparam logic [3:0] own_id = 4'd5;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  in_valid [np];
    logic [noc_params_pkg::flit_width-1:0] in_data [np];
    logic                                  local_in_ready;
    logic [np-2:0]                         dwnstr_credit_increment;
    logic [np-2:0]                         upstr_credit_increment;
    logic [noc_params_pkg::flit_width-1:0] out_data [np];
    logic                                  out_valid [np];

    logic [31:0]                           lfsr_state;
    int                                    cyc_count;
    // Flits seen on the watched output and the cycle of each
    logic [noc_params_pkg::flit_width-1:0] got_q [$];
    int                                    got_cyc [$];

    tb_clock_gen #(.period_ns(clk_period)) u_clk (.clk(clk));

    router_top #(.router_id(own_id)) DUT (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .in_valid                (in_valid),
        .in_data                 (in_data),
        .local_in_ready          (local_in_ready),
        .dwnstr_credit_increment (dwnstr_credit_increment),
        .upstr_credit_increment  (upstr_credit_increment),
        .out_data                (out_data),
        .out_valid               (out_valid)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Right shifting Galois LFSR
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ lfsr_taps;
        end
        return n;
    endfunction

    // One LFSR step per payload bit
    task automatic next_payload(output logic [payload_bits-1:0] payload);
        payload = '0;
        for (int b = 0; b < payload_bits; b++) begin
            lfsr_state = galois_step(lfsr_state);
            payload    = {payload[payload_bits-2:0], lfsr_state[0]};
        end
    endtask

    task automatic make_flit(input logic [3:0] dest,
                             output logic [noc_params_pkg::flit_width-1:0] flit);
        logic [payload_bits-1:0] payload;
        next_payload(payload);
        flit = {dest, payload};
    endtask

    // Expected output by XY order, columns first
    function automatic noc_types_pkg::port_dir_e xy_port(input logic [3:0] dest);
        int dc;
        int dr;
        int oc;
        int orow;
        dc   = int'(dest) % noc_params_pkg::mesh_cols;
        dr   = int'(dest) / noc_params_pkg::mesh_cols;
        oc   = int'(own_id) % noc_params_pkg::mesh_cols;
        orow = int'(own_id) / noc_params_pkg::mesh_cols;
        if (dc > oc) return noc_types_pkg::port_east;
        if (dc < oc) return noc_types_pkg::port_west;
        if (dr > orow) return noc_types_pkg::port_south;
        if (dr < orow) return noc_types_pkg::port_north;
        return noc_types_pkg::port_local;
    endfunction

    // Advance to just after the next rising edge
    task automatic tick();
        @(posedge clk);
        #(stim_delay);
        cyc_count++;
    endtask

    // Record the watched output, then move one cycle on
    task automatic cycle_step(input noc_types_pkg::port_dir_e port);
        if (out_valid[port]) begin
            got_q.push_back(out_data[port]);
            got_cyc.push_back(cyc_count);
        end
        tick();
    endtask

    task automatic clear_inputs();
        for (int p = 0; p < np; p++) begin
            in_valid[p] = 1'b0;
            in_data[p]  = '0;
        end
        dwnstr_credit_increment = '0;
    endtask

    task automatic apply_reset();
        clear_inputs();
        rst_n = 1'b0;
        repeat (10) tick();
        rst_n = 1'b1;
        tick();
    endtask

    task automatic test_reset_state();
        apply_reset();
        for (int p = 0; p < np; p++) begin
            check_value($sformatf("out_valid[%0d]", p), 32'(out_valid[p]), 32'd0);
        end
        check_value("upstr_credit_increment", 32'(upstr_credit_increment), 32'd0);
        check_value("local_in_ready", 32'(local_in_ready), 32'd1);
    endtask

    task automatic test_routing();
        logic [3:0]                            dests [5];
        logic [noc_params_pkg::flit_width-1:0] flit;
        noc_types_pkg::port_dir_e              exp_port;
        dests = '{4'd5, 4'd6, 4'd4, 4'd1, 4'd9};
        apply_reset();
        foreach (dests[d]) begin
            make_flit(dests[d], flit);
            exp_port = xy_port(dests[d]);
            in_valid[noc_types_pkg::port_local] = 1'b1;
            in_data[noc_types_pkg::port_local]  = flit;
            tick();
            in_valid[noc_types_pkg::port_local] = 1'b0;
            // Grant cycle, nothing out yet
            for (int p = 0; p < np; p++) begin
                check_value($sformatf("out_valid[%0d]", p), 32'(out_valid[p]), 32'd0);
            end
            tick();
            for (int p = 0; p < np; p++) begin
                check_value($sformatf("out_valid[%0d]", p), 32'(out_valid[p]),
                            (p == int'(exp_port)) ? 32'd1 : 32'd0);
            end
            check_value($sformatf("out_data[%0d]", int'(exp_port)),
                        32'(out_data[exp_port]), 32'(flit));
            tick();
        end
    endtask

    task automatic test_credit_return();
        logic [noc_params_pkg::flit_width-1:0] flit;
        apply_reset();
        make_flit(own_id, flit);
        in_valid[noc_types_pkg::port_north] = 1'b1;
        in_data[noc_types_pkg::port_north]  = flit;
        check_value("upstr_credit_increment", 32'(upstr_credit_increment), 32'd0);
        tick();
        in_valid[noc_types_pkg::port_north] = 1'b0;
        // North FIFO pops here, bit 0 is the north input
        check_value("upstr_credit_increment", 32'(upstr_credit_increment), 32'h1);
        check_value("out_valid[0]", 32'(out_valid[noc_types_pkg::port_local]), 32'd0);
        tick();
        check_value("upstr_credit_increment", 32'(upstr_credit_increment), 32'd0);
        check_value("out_valid[0]", 32'(out_valid[noc_types_pkg::port_local]), 32'd1);
        check_value("out_data[0]", 32'(out_data[noc_types_pkg::port_local]), 32'(flit));
    endtask

    task automatic test_arbitration();
        logic [noc_params_pkg::flit_width-1:0] n_flits [3];
        logic [noc_params_pkg::flit_width-1:0] s_flits [3];
        logic [noc_params_pkg::flit_width-1:0] exp_q [$];
        int                                    guard;
        apply_reset();
        got_q.delete();
        got_cyc.delete();
        for (int i = 0; i < 3; i++) begin
            make_flit(4'd6, n_flits[i]);
            make_flit(4'd6, s_flits[i]);
            // Pointer starts at local, so north wins first and then they alternate
            exp_q.push_back(n_flits[i]);
            exp_q.push_back(s_flits[i]);
        end
        for (int i = 0; i < 3; i++) begin
            in_valid[noc_types_pkg::port_north] = 1'b1;
            in_data[noc_types_pkg::port_north]  = n_flits[i];
            in_valid[noc_types_pkg::port_south] = 1'b1;
            in_data[noc_types_pkg::port_south]  = s_flits[i];
            // Downstream hands a credit back for every flit it takes
            dwnstr_credit_increment[east_credit_bit] = out_valid[noc_types_pkg::port_east];
            cycle_step(noc_types_pkg::port_east);
        end
        in_valid[noc_types_pkg::port_north] = 1'b0;
        in_valid[noc_types_pkg::port_south] = 1'b0;
        guard = 0;
        while (got_q.size() < 6 && guard < 40) begin
            dwnstr_credit_increment[east_credit_bit] = out_valid[noc_types_pkg::port_east];
            cycle_step(noc_types_pkg::port_east);
            guard++;
        end
        dwnstr_credit_increment = '0;
        if (got_q.size() != 6) begin
            fail_run("East output did not deliver all six contending flits in time");
        end
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("out_data[3] flit %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
            check_value($sformatf("east flit %0d cycle offset", i),
                        32'(got_cyc[i] - got_cyc[0]), 32'(i));
        end
    endtask

    task automatic test_backpressure();
        logic [noc_params_pkg::flit_width-1:0] flits [6];
        int                                    sent;
        int                                    guard;
        apply_reset();
        got_q.delete();
        got_cyc.delete();
        foreach (flits[i]) begin
            make_flit(4'd6, flits[i]);
        end
        sent  = 0;
        guard = 0;
        while (sent < 6 && guard < 20) begin
            in_valid[noc_types_pkg::port_local] = local_in_ready;
            in_data[noc_types_pkg::port_local]  = flits[sent];
            if (local_in_ready) begin
                sent++;
            end
            cycle_step(noc_types_pkg::port_east);
            guard++;
        end
        in_valid[noc_types_pkg::port_local] = 1'b0;
        if (sent != 6) begin
            fail_run("Local input stayed not ready while sending back-pressure flits");
        end
        repeat (12) cycle_step(noc_types_pkg::port_east);
        // Credits exhausted after one buffer's worth
        check_value("east flits before credit return", 32'(got_q.size()),
                    32'(noc_params_pkg::buffer_depth));
        repeat (2) begin
            dwnstr_credit_increment[east_credit_bit] = 1'b1;
            cycle_step(noc_types_pkg::port_east);
            dwnstr_credit_increment[east_credit_bit] = 1'b0;
            cycle_step(noc_types_pkg::port_east);
        end
        // Wait for the two held flits to drain
        guard = 0;
        while (got_q.size() < 6 && guard < 12) begin
            cycle_step(noc_types_pkg::port_east);
            guard++;
        end
        check_value("east flits after credit return", 32'(got_q.size()), 32'd6);
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("out_data[3] flit %0d", i), 32'(got_q[i]), 32'(flits[i]));
        end
    endtask

    // Bound on the whole run, 200 cycles for each test
    initial begin
        #(num_tests * 200 * clk_period);
        fail_run("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        rst_n      = 1'b0;
        lfsr_state = lfsr_seed;
        cyc_count  = 0;
        clear_inputs();
        test_reset_state();
        test_routing();
        test_credit_return();
        test_arbitration();
        test_backpressure();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock source
// Free running clock, low at time zero
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period per phase
    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire
